//--- memcard_sys.f
src/memcard_pkg.sv
src/save_pkg.sv
src/card_bus_if.sv
src/card_dpram.sv
src/memcard.sv
src/card_save_ctrl.sv
src/memcard_sys.sv
tb/tb_clock_gen.sv
tb/memcard_checker.sv
tb/memcard_sys_assert.sv
tb/memcard_sys_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build the memory card testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f memcard_sys.f \
	--top-module memcard_sys_tb -o memcard_sys_sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

out=$(./obj_dir/memcard_sys_sim)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$out" | grep -qx "SIMULATION PASSED"; then
	exit 0
fi
exit 1

//--- src/card_bus_if.sv
/* Internal card buses.
   Byte-wide CPU bus and word-wide host bus into the card core. */

`timescale 1ns/1ps

// ============================================================================
// CPU byte bus
// ============================================================================
interface cpu_card_if;
	import memcard_pkg::*;

	// Byte address from the CPU, odd addresses live in the low lane
	logic [cpu_addr_width-1:0] cda;
	// Write strobe, one byte is written on every edge it is high
	logic                      card_we;
	logic [7:0]                wdata;
	// Read byte, valid one cycle after cda is sampled
	logic [7:0]                rdata;

	modport drv (output cda, output card_we, output wdata, input rdata);
	modport card (input cda, input card_we, input wdata, output rdata);
endinterface

// ============================================================================
// Host word bus
// ============================================================================
interface host_card_if;
	import memcard_pkg::*;

	// Word address, the same on both lanes
	logic [word_addr_width-1:0] addr;
	logic                       wr;
	// Upper byte is the even CPU address, lower byte the odd one
	logic [15:0]                wdata;
	logic [15:0]                rdata;

	modport drv (output addr, output wr, output wdata, input rdata);
	modport card (input addr, input wr, input wdata, output rdata);
endinterface

//--- src/card_dpram.sv
/* Byte-wide true dual-port RAM.
   Two independent ports on one clock, each with a registered read. */

`timescale 1ns/1ps

module card_dpram #(
	parameter int addr_width = 12
) (
	input  logic                  CLK_24M,
	input  logic                  arst_n,
	// Port a
	input  logic [addr_width-1:0] addr_a,
	input  logic                  we_a,
	input  logic [7:0]            din_a,
	output logic [7:0]            dout_a,
	// Port b
	input  logic [addr_width-1:0] addr_b,
	input  logic                  we_b,
	input  logic [7:0]            din_b,
	output logic [7:0]            dout_b
);

	// Storage array, its contents survive reset
	logic [7:0] mem [0:(2**addr_width)-1];

	// Both ports write on the same edge
	// A collision on one address leaves port b's byte, which callers avoid
	always_ff @(posedge CLK_24M) begin
		if (we_a) begin
			mem[addr_a] <= din_a;
		end
		if (we_b) begin
			mem[addr_b] <= din_b;
		end
	end

	// Read registers sample the array before this edge's write lands,
	// so a port reading its own write address returns the old byte
	always_ff @(posedge CLK_24M or negedge arst_n) begin
		if (!arst_n) begin
			dout_a <= 8'h00;
			dout_b <= 8'h00;
		end else begin
			dout_a <= mem[addr_a];
			dout_b <= mem[addr_b];
		end
	end

endmodule

//--- src/card_save_ctrl.sv
/* Auto-save controller.
   Requests a write-back once the card has changed and then stayed quiet. */

`timescale 1ns/1ps

module card_save_ctrl #(
	parameter logic [15:0] save_delay = save_pkg::default_save_delay
) (
	input  logic CLK_24M,
	input  logic arst_n,
	input  logic card_change,
	input  logic save_ack,
	output logic save_req
);
	import save_pkg::*;

	save_state_t state;
	logic [15:0] quiet_cnt;
	// Set when the card changes while the host is already saving
	logic        change_pend;

	// ========================================================================
	// Quiet counter
	// ========================================================================

	// Every change restarts the quiet period in any state
	// Counting on during a pending request keeps the next request aligned
	// to the last change rather than to the acknowledge
	always_ff @(posedge CLK_24M or negedge arst_n) begin
		if (!arst_n) begin
			quiet_cnt <= 16'd0;
		end else if (card_change) begin
			quiet_cnt <= save_delay - 16'd1;
		end else if (quiet_cnt != 16'd0) begin
			quiet_cnt <= quiet_cnt - 16'd1;
		end
	end

	// ========================================================================
	// Save FSM
	// ========================================================================

	always_ff @(posedge CLK_24M or negedge arst_n) begin
		if (!arst_n) begin
			state       <= SAVE_CLEAN;
			change_pend <= 1'b0;
		end else begin
			unique case (state)
				SAVE_CLEAN: begin
					if (card_change) begin
						state <= SAVE_DIRTY;
					end
				end
				SAVE_DIRTY: begin
					// A change in this cycle has just reloaded the counter
					// Leaving on a count of one puts the request save_delay cycles
					// after the change pulse
					if (!card_change && quiet_cnt <= 16'd1) begin
						state <= SAVE_REQUEST;
					end
				end
				SAVE_REQUEST: begin
					if (save_ack) begin
						// Host saved an older image, so newer data still needs one
						if (change_pend || card_change) begin
							state <= SAVE_DIRTY;
						end else begin
							state <= SAVE_CLEAN;
						end
						change_pend <= 1'b0;
					end else if (card_change) begin
						change_pend <= 1'b1;
					end
				end
				default: begin
					state       <= SAVE_CLEAN;
					change_pend <= 1'b0;
				end
			endcase
		end
	end

	// Request holds for as long as the host leaves it unacknowledged
	assign save_req = (state == SAVE_REQUEST);

endmodule

//--- src/memcard.sv
/* Memory card core.
   Maps the CPU byte bus and the host word bus onto two byte-lane RAMs. */

`timescale 1ns/1ps

module memcard (
	input  logic        CLK_24M,
	input  logic        arst_n,
	input  logic        system_cd,
	cpu_card_if.card    cpu,
	host_card_if.card   host,
	output logic        card_change
);
	import memcard_pkg::*;

	card_mode_t                 mode;
	logic [word_addr_width-1:0] cpu_word_addr;
	logic                       we_lo;
	logic                       we_hi;
	logic                       lane_sel_q;
	logic [7:0]                 cpu_lo;
	logic [7:0]                 cpu_hi;
	logic [7:0]                 host_lo;
	logic [7:0]                 host_hi;

	// ========================================================================
	// CPU address mapping
	// ========================================================================

	assign mode = system_cd ? CARD_CD : CARD_CART;

	// Cartridge cards only decode 2 kB, higher CPU addresses fold back
	// onto the start of the card
	always_comb begin
		if (mode == CARD_CD) begin
			cpu_word_addr = cpu.cda[cpu_addr_width-1:1];
		end else begin
			cpu_word_addr = {{(word_addr_width - cart_word_addr_width){1'b0}},
				cpu.cda[cart_word_addr_width:1]};
		end
	end

	// Odd bytes go to the low lane and even bytes to the high lane
	assign we_lo = cpu.card_we & cpu.cda[0];
	assign we_hi = cpu.card_we & ~cpu.cda[0];

	// ========================================================================
	// Registered side info
	// ========================================================================

	// Lane select follows the RAM read latency, so the byte picked
	// matches the address that was sampled and not the current one
	// Change pulse marks the cycle after each CPU write
	always_ff @(posedge CLK_24M or negedge arst_n) begin
		if (!arst_n) begin
			lane_sel_q  <= 1'b0;
			card_change <= 1'b0;
		end else begin
			lane_sel_q  <= cpu.cda[0];
			card_change <= cpu.card_we;
		end
	end

	assign cpu.rdata  = lane_sel_q ? cpu_lo : cpu_hi;
	// Host words carry the even byte on top
	assign host.rdata = {host_hi, host_lo};

	// ========================================================================
	// Byte lanes
	// ========================================================================

	card_dpram #(.addr_width(word_addr_width)) lane_lo (
		.CLK_24M (CLK_24M),
		.arst_n  (arst_n),
		.addr_a  (cpu_word_addr),
		.we_a    (we_lo),
		.din_a   (cpu.wdata),
		.dout_a  (cpu_lo),
		.addr_b  (host.addr),
		.we_b    (host.wr),
		.din_b   (host.wdata[7:0]),
		.dout_b  (host_lo)
	);

	card_dpram #(.addr_width(word_addr_width)) lane_hi (
		.CLK_24M (CLK_24M),
		.arst_n  (arst_n),
		.addr_a  (cpu_word_addr),
		.we_a    (we_hi),
		.din_a   (cpu.wdata),
		.dout_a  (cpu_hi),
		.addr_b  (host.addr),
		.we_b    (host.wr),
		.din_b   (host.wdata[15:8]),
		.dout_b  (host_hi)
	);

endmodule

//--- src/memcard_pkg.sv
/* Memory card geometry package.
   Address widths of the CPU and host views and the card mode type. */

package memcard_pkg;

	// ========================================================================
	// Address geometry
	// ========================================================================

	// CPU side addresses the card one byte at a time, 8 kB in CD mode
	parameter int cpu_addr_width = 13;

	// Each lane RAM holds one byte per word, so the word address is one bit
	// narrower than the CPU byte address
	parameter int word_addr_width = 12;

	// Cartridge cards are 2 kB, which leaves 1k words per lane
	parameter int cart_word_addr_width = 10;

	// ========================================================================
	// Card mode
	// ========================================================================

	// Cartridge systems see the small card, CD systems see the full card
	typedef enum logic {
		CARD_CART = 1'b0,
		CARD_CD   = 1'b1
	} card_mode_t;

endpackage

//--- src/memcard_sys.sv
/* Memory card subsystem top.
   Card core plus auto-save controller behind plain CPU and host ports. */

`timescale 1ns/1ps

module memcard_sys #(
	parameter logic [15:0] save_delay = save_pkg::default_save_delay
) (
	input  logic                                   CLK_24M,
	input  logic                                   arst_n,
	input  logic                                   system_cd,
	// CPU side, one byte per access
	input  logic [memcard_pkg::cpu_addr_width-1:0] cda,
	input  logic                                   card_we,
	input  logic [7:0]                             cpu_wdata,
	output logic [7:0]                             cpu_rdata,
	// Host side, one word per access
	input  logic [memcard_pkg::word_addr_width-1:0] host_addr,
	input  logic                                   host_wr,
	input  logic [15:0]                            host_wdata,
	output logic [15:0]                            host_rdata,
	// Change and save handshake
	output logic                                   card_change,
	input  logic                                   save_ack,
	output logic                                   save_req
);

	// ========================================================================
	// Internal buses
	// ========================================================================

	cpu_card_if  cpu_bus ();
	host_card_if host_bus ();

	// Top ports act as the driving side of both buses
	assign cpu_bus.cda      = cda;
	assign cpu_bus.card_we  = card_we;
	assign cpu_bus.wdata    = cpu_wdata;
	assign cpu_rdata        = cpu_bus.rdata;

	assign host_bus.addr    = host_addr;
	assign host_bus.wr      = host_wr;
	assign host_bus.wdata   = host_wdata;
	assign host_rdata       = host_bus.rdata;

	// ========================================================================
	// Card core and save control
	// ========================================================================

	memcard memcard_inst (
		.CLK_24M     (CLK_24M),
		.arst_n      (arst_n),
		.system_cd   (system_cd),
		.cpu         (cpu_bus.card),
		.host        (host_bus.card),
		.card_change (card_change)
	);

	// Change pulse feeds both the top port and the save controller
	card_save_ctrl #(.save_delay(save_delay)) card_save_ctrl_inst (
		.CLK_24M     (CLK_24M),
		.arst_n      (arst_n),
		.card_change (card_change),
		.save_ack    (save_ack),
		.save_req    (save_req)
	);

endmodule

//--- src/save_pkg.sv
/* Auto-save package.
   State type of the save controller and its default quiet period. */

package save_pkg;

	// Card contents match storage, or have changed, or are waiting for the host
	typedef enum logic [1:0] {
		SAVE_CLEAN   = 2'd0,
		SAVE_DIRTY   = 2'd1,
		SAVE_REQUEST = 2'd2
	} save_state_t;

	// Quiet period before a save is requested, counted in CLK_24M cycles
	// A burst of CPU writes to the card normally finishes well inside this
	parameter logic [15:0] default_save_delay = 16'd4096;

endpackage

//--- tb/memcard_checker.sv
/* Memory card result checker.
   Compares DUT read data, change pulses and save timing against the test table. */

`timescale 1ns/1ps

module memcard_checker (
	input  logic         CLK_24M,
	input  logic         arst_n,
	input  logic         card_change,
	input  logic         save_req,
	input  logic [7:0]   cpu_rdata,
	input  logic [15:0]  host_rdata,
	input  logic         valid,
	input  logic [127:0] name,
	input  logic [2:0]   op,
	input  logic [15:0]  exp,
	input  logic         done,
	output int           pass_cnt,
	output int           fail_cnt,
	output logic         finished
);

	// Operation codes use the same encoding as the testbench table
	localparam logic [2:0] op_cpu_wr  = 3'd0;
	localparam logic [2:0] op_cpu_rd  = 3'd1;
	localparam logic [2:0] op_host_wr = 3'd2;
	localparam logic [2:0] op_host_rd = 3'd3;
	localparam logic [2:0] op_save    = 3'd4;
	localparam logic [2:0] op_ack     = 3'd5;

	int           cyc = 0;
	int           last_change_cyc = 0;
	int           last_delay = -1;
	int           write_cnt = 0;
	int           change_cnt = 0;
	logic         req_q = 1'b0;
	logic         pend = 1'b0;
	logic [127:0] pend_name;
	logic [2:0]   pend_op;
	logic [15:0]  pend_exp;
	logic [15:0]  actual;

	initial begin
		pass_cnt = 0;
		fail_cnt = 0;
		finished = 1'b0;
	end

	task automatic compare(input logic [127:0] tname, input int e, input int a);
		if (e == a) begin
			$display("PASS %0s value %0h", tname, a);
			pass_cnt++;
		end else begin
			$display("ERR %0s expected %0h actual %0h", tname, e, a);
			fail_cnt++;
		end
	endtask

	// All sampling is on the rising edge while the driver moves on the falling one
	always @(posedge CLK_24M) begin
		cyc++;
		if (arst_n) begin
			// Save delay is measured from the last sampled change pulse
			if (card_change) begin
				change_cnt++;
				last_change_cyc = cyc;
			end
			if (save_req && !req_q) begin
				last_delay = cyc - last_change_cyc;
			end
			req_q = save_req;

			// Reads, writes and acknowledges settle one cycle after they are sampled
			if (pend) begin
				if (pend_op == op_cpu_rd) begin
					actual = {8'h00, cpu_rdata};
				end else if (pend_op == op_host_rd) begin
					actual = host_rdata;
				end else if (pend_op == op_ack) begin
					actual = {15'd0, save_req};
				end else begin
					// Only a CPU write is followed by a change pulse
					actual = {15'd0, card_change};
				end
				compare(pend_name, int'(pend_exp), int'(actual));
				pend = 1'b0;
			end

			if (valid) begin
				case (op)
					op_cpu_wr, op_cpu_rd, op_host_wr, op_host_rd, op_ack: begin
						if (op == op_cpu_wr) begin
							write_cnt++;
						end
						pend      = 1'b1;
						pend_name = name;
						pend_op   = op;
						pend_exp  = exp;
					end
					op_save: begin
						compare(name, int'(exp), last_delay);
					end
					default: begin
						$display("Test %0s has an unknown operation", name);
						fail_cnt++;
					end
				endcase
			end

			// Every CPU write must have produced exactly one change pulse
			if (done && !finished) begin
				if (change_cnt != write_cnt) begin
					$display("Change pulses do not match CPU writes, %0d pulses for %0d writes",
						change_cnt, write_cnt);
					fail_cnt++;
				end
				finished = 1'b1;
			end
		end
	end

endmodule

//--- tb/memcard_sys_assert.sv
/* Memory card protocol assertions.
   Reset value, change pulse width and request hold of the subsystem. */

`timescale 1ns/1ps

module memcard_sys_assert (
	input logic CLK_24M,
	input logic arst_n,
	input logic card_we,
	input logic card_change,
	input logic save_ack,
	input logic save_req
);

	// No save request straight out of reset
	a_reset_req: assert property (@(posedge CLK_24M) !arst_n |=> !save_req)
		else $error("save_req high after reset");

	// A change pulse only ever follows a write cycle
	a_change_width: assert property (@(posedge CLK_24M) disable iff (!arst_n)
		card_change |-> $past(card_we))
		else $error("card_change outlasts card_we");

	// Host back-pressure leaves the request standing
	a_req_hold: assert property (@(posedge CLK_24M) disable iff (!arst_n)
		save_req && !save_ack |=> save_req)
		else $error("save_req dropped without save_ack");

endmodule

bind memcard_sys memcard_sys_assert memcard_sys_assert_inst (
	.CLK_24M     (CLK_24M),
	.arst_n      (arst_n),
	.card_we     (card_we),
	.card_change (card_change),
	.save_ack    (save_ack),
	.save_req    (save_req)
);

//--- tb/memcard_sys_tb.sv
/* Memory card subsystem testbench.
   Applies a stimulus table on the falling edge and hands each test to the checker. */

`timescale 1ns/1ps

module memcard_sys_tb;
	import memcard_pkg::*;

	localparam logic [15:0] save_delay = 16'd20;
	localparam logic [2:0]  op_cpu_wr  = 3'd0;
	localparam logic [2:0]  op_cpu_rd  = 3'd1;
	localparam logic [2:0]  op_host_wr = 3'd2;
	localparam logic [2:0]  op_host_rd = 3'd3;
	localparam logic [2:0]  op_save    = 3'd4;
	localparam logic [2:0]  op_ack     = 3'd5;

	typedef struct packed {
		logic [127:0] name;
		card_mode_t   mode;
		logic [2:0]   op;
		logic [12:0]  addr;
		logic [15:0]  data;
		logic [15:0]  exp;
	} test_t;

	test_t tests[$];
	logic CLK_24M, arst_n, system_cd, card_we, host_wr, card_change, save_ack, save_req;
	logic [cpu_addr_width-1:0]  cda;
	logic [7:0]                 cpu_wdata, cpu_rdata;
	logic [word_addr_width-1:0] host_addr;
	logic [15:0]                host_wdata, host_rdata, chk_exp;
	logic                       chk_valid, chk_done, finished;
	logic [127:0]               chk_name;
	logic [2:0]                 chk_op;
	int                         pass_cnt, fail_cnt;
	int                         cycle_cnt = 0;
	int                         cycle_limit = 1000000;

	tb_clock_gen clock_gen_inst (.CLK_24M(CLK_24M), .arst_n(arst_n));

	memcard_sys #(.save_delay(save_delay)) memcard_sys_inst (
		.CLK_24M(CLK_24M), .arst_n(arst_n), .system_cd(system_cd),
		.cda(cda), .card_we(card_we), .cpu_wdata(cpu_wdata), .cpu_rdata(cpu_rdata),
		.host_addr(host_addr), .host_wr(host_wr), .host_wdata(host_wdata),
		.host_rdata(host_rdata), .card_change(card_change),
		.save_ack(save_ack), .save_req(save_req)
	);

	memcard_checker checker_inst (
		.CLK_24M(CLK_24M), .arst_n(arst_n), .card_change(card_change),
		.save_req(save_req), .cpu_rdata(cpu_rdata), .host_rdata(host_rdata),
		.valid(chk_valid), .name(chk_name), .op(chk_op), .exp(chk_exp),
		.done(chk_done), .pass_cnt(pass_cnt), .fail_cnt(fail_cnt), .finished(finished)
	);

	task automatic add_test(input logic [127:0] name, input card_mode_t mode,
			input logic [2:0] op, input logic [12:0] addr, input logic [15:0] data,
			input logic [15:0] exp);
		test_t t;
		t.name = name;
		t.mode = mode;
		t.op   = op;
		t.addr = addr;
		t.data = data;
		t.exp  = exp;
		tests.push_back(t);
	endtask

	// ========================================================================
	// Stimulus table
	// ========================================================================
	task automatic build_table();
		// Even bytes sit in the upper host byte, odd bytes in the lower one
		// Write entries expect the change pulse level of the following cycle
		add_test("cd_wr_even", CARD_CD, op_cpu_wr, 13'h0004, 16'h005A, 16'h0001);
		add_test("cd_wr_odd", CARD_CD, op_cpu_wr, 13'h0005, 16'h00A5, 16'h0001);
		add_test("cd_wr_hi_even", CARD_CD, op_cpu_wr, 13'h1A02, 16'h003C, 16'h0001);
		add_test("cd_wr_hi_odd", CARD_CD, op_cpu_wr, 13'h1A03, 16'h00C3, 16'h0001);
		add_test("cd_wr_low", CARD_CD, op_cpu_wr, 13'h0202, 16'h0011, 16'h0001);
		add_test("cd_rd_even", CARD_CD, op_cpu_rd, 13'h0004, 16'h0000, 16'h005A);
		add_test("cd_rd_odd", CARD_CD, op_cpu_rd, 13'h0005, 16'h0000, 16'h00A5);
		add_test("cd_rd_hi_even", CARD_CD, op_cpu_rd, 13'h1A02, 16'h0000, 16'h003C);
		add_test("cd_rd_hi_odd", CARD_CD, op_cpu_rd, 13'h1A03, 16'h0000, 16'h00C3);
		add_test("host_rd_lo", CARD_CD, op_host_rd, 13'h0002, 16'h0000, 16'h5AA5);
		add_test("host_rd_hi", CARD_CD, op_host_rd, 13'h0D01, 16'h0000, 16'h3CC3);
		add_test("host_wr", CARD_CD, op_host_wr, 13'h0123, 16'hBEEF, 16'h0000);
		add_test("host_wr_rd_even", CARD_CD, op_cpu_rd, 13'h0246, 16'h0000, 16'h00BE);
		add_test("host_wr_rd_odd", CARD_CD, op_cpu_rd, 13'h0247, 16'h0000, 16'h00EF);
		add_test("save_delay_1", CARD_CD, op_save, 13'h0000, 16'h0000, 16'd20);
		add_test("save_ack_1", CARD_CD, op_ack, 13'h0000, 16'h0000, 16'h0000);
		// Cartridge mode folds everything above 2 kB onto the first 2 kB
		add_test("cart_wr", CARD_CART, op_cpu_wr, 13'h0010, 16'h0077, 16'h0001);
		add_test("cart_rd_alias", CARD_CART, op_cpu_rd, 13'h0810, 16'h0000, 16'h0077);
		add_test("cart_rd_masked", CARD_CART, op_cpu_rd, 13'h1A02, 16'h0000, 16'h0011);
		add_test("save_delay_2", CARD_CD, op_save, 13'h0000, 16'h0000, 16'd20);
		// A write during a pending request must bring a second request
		// The read in between lets the change pulse land before the acknowledge
		add_test("wr_during_req", CARD_CD, op_cpu_wr, 13'h0100, 16'h0042, 16'h0001);
		add_test("rd_during_req", CARD_CD, op_cpu_rd, 13'h0100, 16'h0000, 16'h0042);
		add_test("save_ack_2", CARD_CD, op_ack, 13'h0000, 16'h0000, 16'h0000);
		add_test("save_delay_3", CARD_CD, op_save, 13'h0000, 16'h0000, 16'd20);
		add_test("save_ack_3", CARD_CD, op_ack, 13'h0000, 16'h0000, 16'h0000);
		add_test("rd_late_write", CARD_CD, op_cpu_rd, 13'h0100, 16'h0000, 16'h0042);
	endtask

	// Called on a falling edge so strobes from the previous test drop here
	task automatic apply_test(input test_t t);
		card_we   = 1'b0;
		host_wr   = 1'b0;
		save_ack  = 1'b0;
		chk_valid = 1'b0;
		system_cd = (t.mode == CARD_CD);
		case (t.op)
			op_cpu_wr: begin
				cda       = t.addr;
				cpu_wdata = t.data[7:0];
				card_we   = 1'b1;
			end
			op_cpu_rd: cda = t.addr;
			op_host_wr: begin
				host_addr  = t.addr[11:0];
				host_wdata = t.data;
				host_wr    = 1'b1;
			end
			op_host_rd: host_addr = t.addr[11:0];
			op_save: begin
				while (!save_req) @(negedge CLK_24M);
			end
			default: save_ack = 1'b1;
		endcase
		chk_name  = t.name;
		chk_op    = t.op;
		chk_exp   = t.exp;
		chk_valid = 1'b1;
	endtask

	// Each test may wait out one quiet period plus some slack
	always @(posedge CLK_24M) begin
		cycle_cnt++;
		if (cycle_cnt >= cycle_limit) begin
			$display("Run timed out after %0d cycles", cycle_cnt);
			$display("SIMULATION FAILED");
			$finish;
		end
	end

	initial begin
		system_cd  = 1'b1;
		cda        = '0;
		card_we    = 1'b0;
		cpu_wdata  = 8'h00;
		host_addr  = '0;
		host_wr    = 1'b0;
		host_wdata = 16'h0000;
		save_ack   = 1'b0;
		chk_valid  = 1'b0;
		chk_name   = '0;
		chk_op     = 3'd0;
		chk_exp    = 16'h0000;
		chk_done   = 1'b0;
		build_table();
		cycle_limit = tests.size() * (int'(save_delay) + 10) + 20;
		wait (arst_n);
		foreach (tests[i]) begin
			@(negedge CLK_24M);
			apply_test(tests[i]);
		end
		@(negedge CLK_24M);
		card_we   = 1'b0;
		host_wr   = 1'b0;
		save_ack  = 1'b0;
		chk_valid = 1'b0;
		@(negedge CLK_24M);
		chk_done = 1'b1;
		while (!finished) @(negedge CLK_24M);
		$display("Tests passed %0d failed %0d", pass_cnt, fail_cnt);
		if (fail_cnt == 0) begin
			$display("SIMULATION PASSED");
		end else begin
			$display("SIMULATION FAILED");
		end
		$finish;
	end

endmodule

//--- tb/tb_clock_gen.sv
/* Testbench clock and reset source.
   Free-running 10 ns clock with reset held low for two cycles. */

`timescale 1ns/1ps

module tb_clock_gen (
	output logic CLK_24M,
	output logic arst_n
);

	initial begin
		CLK_24M = 1'b0;
		forever #5 CLK_24M = ~CLK_24M;
	end

	// Release away from the rising edge so the flops see a clean deassert
	initial begin
		arst_n = 1'b0;
		repeat (2) @(posedge CLK_24M);
		@(negedge CLK_24M);
		arst_n = 1'b1;
	end

endmodule
